//--- Bender.yml
package:
  name: csr_subsystem

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - csrPkg.sv
      - csrBusPort.sv
      - pmpEntry.sv
      - csrMachine.sv
      - csrReadSel.sv
      - csrSubsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - csrTb.sv

//--- csrBusPort.sv
//////////////////////////////
// Wishbone classic slave for CSR access
// One strobe per bus cycle, answer one cycle later
// Never stalls; ack or err lasts one cycle
// Address and data are passed straight to the CSRs
//////////////////////////////
`timescale 1ns/1ps

module csrBusPort (
  input  logic              clk,
  input  logic              rstN,
  input  logic              wbCyc,
  input  logic              wbStb,
  input  logic              wbWe,
  input  csrPkg::csrAdr_t   wbAdr,
  input  csrPkg::csrWord_t  wbDatIn,
  input  csrPkg::csrWord_t  csrRdData,
  input  logic              csrIllegal,
  output csrPkg::csrWord_t  wbDatOut,
  output logic              wbAck,
  output logic              wbErr,
  output csrPkg::csrAdr_t   csrAdr,
  output csrPkg::csrWord_t  csrWrData,
  output logic              csrWrite
);

  // Set for the cycle in which the answer is on the bus
  logic answered;
  // Request seen for the first time
  logic newReq;

  assign newReq = wbCyc & wbStb & ~answered;

  // Address and write data go to the register blocks as they are
  assign csrAdr    = wbAdr;
  assign csrWrData = wbDatIn;

  // Write strobe only for legal accesses
  assign csrWrite = newReq & wbWe & ~csrIllegal;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      answered <= 1'b0;
      wbAck    <= 1'b0;
      wbErr    <= 1'b0;
    end else begin
      answered <= newReq;
      // Legal access acks, anything else errs
      wbAck    <= newReq & ~csrIllegal;
      wbErr    <= newReq & csrIllegal;
    end
  end

  // Read data sampled with the request, before any same-cycle update
  always_ff @(posedge clk) begin
    if (newReq) begin
      wbDatOut <= csrRdData;
    end
  end

  // The two answers exclude each other
  assert property (@(posedge clk) disable iff (!rstN) !(wbAck && wbErr))
    else $error("wbAck and wbErr high together");

endmodule

//--- csrMachine.sv
//////////////////////////////
// Machine-mode registers of an RV32 hart
// Only MIE, MPIE and MPP exist in mstatus
// Trap beats a bus write to the same register
// mip mirrors the input pin, writes ignored
// misa and mtinst ignore writes, ID registers reject them
//////////////////////////////
`timescale 1ns/1ps
`include "csr_consts.svh"

module csrMachine (
  input  logic                clk,
  input  logic                rstN,
  input  logic                csrWrite,
  input  csrPkg::csrAdr_t     csrAdr,
  input  csrPkg::csrWord_t    csrWrData,
  input  logic                mTrap,
  input  csrPkg::csrWord_t    nextEpc,
  input  csrPkg::trapCause_t  nextCause,
  input  csrPkg::csrWord_t    nextMtval,
  input  logic [11:0]         mip,
  output csrPkg::csrWord_t    mReadVal,
  output logic                mHit,
  output logic                mReadOnly,
  output csrPkg::csrWord_t    mtvec,
  output csrPkg::csrWord_t    mepc,
  output logic [15:0]         medeleg,
  output logic [11:0]         mideleg,
  output logic [11:0]         mie,
  output logic                mstatusMie
);
  import csrPkg::*;

  csrWord_t   mscratch;
  csrWord_t   mcause;
  csrWord_t   mtval;
  csrWord_t   mcounteren;
  csrWord_t   mcountinhibit;
  csrWord_t   mstatusVal;
  logic       mstatusMpie;
  logic [1:0] mstatusMpp;

  logic wrMstatus;
  logic wrMtvec;
  logic wrMedeleg;
  logic wrMideleg;
  logic wrMie;
  logic wrMscratch;
  logic wrMepc;
  logic wrMcause;
  logic wrMtval;
  logic wrMcounteren;
  logic wrMcountinhibit;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  assign wrMstatus       = csrWrite & (csrAdr == `CSR_ADR_MSTATUS);
  assign wrMtvec         = csrWrite & (csrAdr == `CSR_ADR_MTVEC);
  assign wrMedeleg       = csrWrite & (csrAdr == `CSR_ADR_MEDELEG);
  assign wrMideleg       = csrWrite & (csrAdr == `CSR_ADR_MIDELEG);
  assign wrMie           = csrWrite & (csrAdr == `CSR_ADR_MIE);
  assign wrMscratch      = csrWrite & (csrAdr == `CSR_ADR_MSCRATCH);
  assign wrMepc          = csrWrite & (csrAdr == `CSR_ADR_MEPC);
  assign wrMcause        = csrWrite & (csrAdr == `CSR_ADR_MCAUSE);
  assign wrMtval         = csrWrite & (csrAdr == `CSR_ADR_MTVAL);
  assign wrMcounteren    = csrWrite & (csrAdr == `CSR_ADR_MCOUNTEREN);
  assign wrMcountinhibit = csrWrite & (csrAdr == `CSR_ADR_MCOUNTINHIBIT);

  //////////////////////////////
  // Registers
  //////////////////////////////

  // mstatus fields, trap stacks MIE and forces machine mode
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mstatusMie  <= 1'b0;
      mstatusMpie <= 1'b0;
      mstatusMpp  <= 2'b00;
    end else if (mTrap) begin
      mstatusMpie <= mstatusMie;
      mstatusMie  <= 1'b0;
      mstatusMpp  <= 2'b11;
    end else if (wrMstatus) begin
      mstatusMie  <= csrWrData[3];
      mstatusMpie <= csrWrData[7];
      mstatusMpp  <= csrWrData[12:11];
    end
  end

  // Trap-loaded registers, trap has priority
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (mTrap) begin
      mepc   <= nextEpc;
      // Interrupt flag moves to the top bit
      mcause <= {nextCause[4], {(`CSR_XLEN-5){1'b0}}, nextCause[3:0]};
      mtval  <= nextMtval;
    end else begin
      if (wrMepc) mepc <= csrWrData;
      if (wrMcause) mcause <= csrWrData;
      if (wrMtval) mtval <= csrWrData;
    end
  end

  // Plain bus-written registers
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mtvec         <= '0;
      medeleg       <= '0;
      mideleg       <= '0;
      mie           <= '0;
      mscratch      <= '0;
      mcounteren    <= '0;
      mcountinhibit <= '0;
    end else begin
      // Mode encoding 2 and 3 reserved, bit 1 kept clear
      if (wrMtvec) mtvec <= {csrWrData[`CSR_XLEN-1:2], 1'b0, csrWrData[0]};
      if (wrMedeleg) medeleg <= csrWrData[15:0] & `CSR_MEDELEG_MASK;
      if (wrMideleg) mideleg <= csrWrData[11:0] & `CSR_MIDELEG_MASK;
      if (wrMie) mie <= csrWrData[11:0];
      if (wrMscratch) mscratch <= csrWrData;
      if (wrMcounteren) mcounteren <= csrWrData;
      if (wrMcountinhibit) mcountinhibit <= csrWrData;
    end
  end

  //////////////////////////////
  // Read decode
  //////////////////////////////

  // MPP at 12:11, MPIE at 7, MIE at 3
  assign mstatusVal = {{(`CSR_XLEN-13){1'b0}}, mstatusMpp, 3'b000, mstatusMpie,
                       3'b000, mstatusMie, 3'b000};

  always_comb begin
    mReadVal  = '0;
    mHit      = 1'b1;
    mReadOnly = 1'b0;
    case (csrAdr)
      `CSR_ADR_MSTATUS:       mReadVal = mstatusVal;
      `CSR_ADR_MISA:          mReadVal = `CSR_MISA_VAL;
      `CSR_ADR_MEDELEG:       mReadVal = {{(`CSR_XLEN-16){1'b0}}, medeleg};
      `CSR_ADR_MIDELEG:       mReadVal = {{(`CSR_XLEN-12){1'b0}}, mideleg};
      `CSR_ADR_MIE:           mReadVal = {{(`CSR_XLEN-12){1'b0}}, mie};
      `CSR_ADR_MTVEC:         mReadVal = mtvec;
      `CSR_ADR_MCOUNTEREN:    mReadVal = mcounteren;
      `CSR_ADR_MCOUNTINHIBIT: mReadVal = mcountinhibit;
      `CSR_ADR_MSCRATCH:      mReadVal = mscratch;
      `CSR_ADR_MEPC:          mReadVal = mepc;
      `CSR_ADR_MCAUSE:        mReadVal = mcause;
      `CSR_ADR_MTVAL:         mReadVal = mtval;
      `CSR_ADR_MIP:           mReadVal = {{(`CSR_XLEN-12){1'b0}}, mip};
      // Trivial zero
      `CSR_ADR_MTINST:        mReadVal = '0;
      // ID block, read-only by address
      `CSR_ADR_MVENDORID,
      `CSR_ADR_MARCHID,
      `CSR_ADR_MHARTID,
      `CSR_ADR_MCONFIGPTR: begin
        mReadVal  = '0;
        mReadOnly = 1'b1;
      end
      `CSR_ADR_MIMPID: begin
        mReadVal  = `CSR_MIMPID_VAL;
        mReadOnly = 1'b1;
      end
      default: mHit = 1'b0;
    endcase
  end

  // Trap pulse from the core must be clean once out of reset
  assert property (@(posedge clk) disable iff (!rstN) !$isunknown(mTrap))
    else $error("mTrap unknown");

endmodule

//--- csrPkg.sv
//////////////////////////////
// Shared types of the machine CSR block
// Word width follows CSR_XLEN
// Cause code bit 4 marks an interrupt
//////////////////////////////
`include "csr_consts.svh"

package csrPkg;

  //////////////////////////////
  // Register and address types
  //////////////////////////////

  // One register value
  typedef logic [`CSR_XLEN-1:0] csrWord_t;

  // 12-bit CSR address as decoded by every block
  typedef logic [11:0] csrAdr_t;

  //////////////////////////////
  // Trap types
  //////////////////////////////

  // Top bit set for interrupts
  // Low four bits hold the exception or interrupt code
  typedef logic [4:0] trapCause_t;

endpackage

//--- csrReadSel.sv
//////////////////////////////
// Read mux and legality check
// Combinational, PMP ranges decoded here
// Illegal accesses read as zero
//////////////////////////////
`timescale 1ns/1ps
`include "csr_consts.svh"

module csrReadSel (
  input  csrPkg::csrAdr_t                                csrAdr,
  input  logic                                           wbWe,
  input  csrPkg::csrWord_t                               mReadVal,
  input  logic                                           mHit,
  input  logic                                           mReadOnly,
  input  logic [`CSR_PMP_ENTRIES*8-1:0]                  pmpCfg,
  input  logic [`CSR_PMP_ENTRIES*(`CSR_PA_BITS-2)-1:0]   pmpAddr,
  output csrPkg::csrWord_t                               csrRdData,
  output logic                                           csrIllegal
);
  import csrPkg::*;

  localparam int unsigned AddrW     = `CSR_PA_BITS - 2;
  // One pmpcfg register per four entries
  localparam csrAdr_t     CfgRegs   = csrAdr_t'(`CSR_PMP_ENTRIES / 4);
  localparam csrAdr_t     AddrRegs  = csrAdr_t'(`CSR_PMP_ENTRIES);

  csrAdr_t  cfgOff;
  csrAdr_t  addrOff;
  logic     cfgHit;
  logic     addrHit;
  csrWord_t rdVal;

  // Offsets wrap below the base, so one compare covers both ends
  assign cfgOff  = csrAdr - `CSR_ADR_PMPCFG0;
  assign addrOff = csrAdr - `CSR_ADR_PMPADDR0;
  assign cfgHit  = (cfgOff < CfgRegs);
  assign addrHit = (addrOff < AddrRegs);

  always_comb begin
    if (addrHit) begin
      rdVal = csrWord_t'(pmpAddr[addrOff*AddrW +: AddrW]);
    end else if (cfgHit) begin
      // Entry 4g in the low byte
      rdVal = csrWord_t'(pmpCfg[cfgOff*32 +: 32]);
    end else begin
      rdVal = mReadVal;
    end
  end

  // Unmapped, or a write to a read-only ID register
  assign csrIllegal = ~(addrHit | cfgHit | mHit) | (wbWe & mReadOnly);
  assign csrRdData  = csrIllegal ? '0 : rdVal;

endmodule

//--- csrSubsystem.sv
//////////////////////////////
// Machine CSR block behind a Wishbone slave
// Trap port loads mepc, mcause, mtval
// Register state exported for the core
//////////////////////////////
`timescale 1ns/1ps
`include "csr_consts.svh"

module csrSubsystem (
  input  logic                clk,
  input  logic                rstN,
  input  logic                wbCyc,
  input  logic                wbStb,
  input  logic                wbWe,
  input  csrPkg::csrAdr_t     wbAdr,
  input  csrPkg::csrWord_t    wbDatIn,
  output csrPkg::csrWord_t    wbDatOut,
  output logic                wbAck,
  output logic                wbErr,
  input  logic                mTrap,
  input  csrPkg::csrWord_t    nextEpc,
  input  csrPkg::trapCause_t  nextCause,
  input  csrPkg::csrWord_t    nextMtval,
  input  logic [11:0]         mip,
  output csrPkg::csrWord_t    mtvec,
  output csrPkg::csrWord_t    mepc,
  output logic [15:0]         medeleg,
  output logic [11:0]         mideleg,
  output logic [11:0]         mie,
  output logic                mstatusMie
);
  import csrPkg::*;

  localparam int unsigned AddrW = `CSR_PA_BITS - 2;

  csrAdr_t  csrAdr;
  csrWord_t csrWrData;
  logic     csrWrite;
  csrWord_t csrRdData;
  logic     csrIllegal;
  csrWord_t mReadVal;
  logic     mHit;
  logic     mReadOnly;

  logic [`CSR_PMP_ENTRIES*8-1:0]     pmpCfg;
  logic [`CSR_PMP_ENTRIES*AddrW-1:0] pmpAddr;
  // One extra slot so the last entry sees an unlocked neighbour
  logic [`CSR_PMP_ENTRIES:0]         pmpLocked;
  logic [`CSR_PMP_ENTRIES:0]         pmpTor;

  assign pmpLocked[`CSR_PMP_ENTRIES] = 1'b0;
  assign pmpTor[`CSR_PMP_ENTRIES]    = 1'b0;

  csrBusPort u_busPort (
    .clk(clk), .rstN(rstN),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatIn(wbDatIn),
    .csrRdData(csrRdData), .csrIllegal(csrIllegal),
    .wbDatOut(wbDatOut), .wbAck(wbAck), .wbErr(wbErr),
    .csrAdr(csrAdr), .csrWrData(csrWrData), .csrWrite(csrWrite)
  );

  // PMP chain, each entry watches the one above
  for (genvar i = 0; i < `CSR_PMP_ENTRIES; i++) begin : gPmp
    pmpEntry #(.Index(i)) u_pmpEntry (
      .clk(clk), .rstN(rstN),
      .csrWrite(csrWrite), .csrAdr(csrAdr), .csrWrData(csrWrData),
      .nextLocked(pmpLocked[i+1]), .nextTor(pmpTor[i+1]),
      .cfg(pmpCfg[i*8 +: 8]), .addr(pmpAddr[i*AddrW +: AddrW]),
      .locked(pmpLocked[i]), .tor(pmpTor[i])
    );
  end

  csrMachine u_machine (
    .clk(clk), .rstN(rstN),
    .csrWrite(csrWrite), .csrAdr(csrAdr), .csrWrData(csrWrData),
    .mTrap(mTrap), .nextEpc(nextEpc), .nextCause(nextCause), .nextMtval(nextMtval),
    .mip(mip),
    .mReadVal(mReadVal), .mHit(mHit), .mReadOnly(mReadOnly),
    .mtvec(mtvec), .mepc(mepc), .medeleg(medeleg), .mideleg(mideleg),
    .mie(mie), .mstatusMie(mstatusMie)
  );

  csrReadSel u_readSel (
    .csrAdr(csrAdr), .wbWe(wbWe),
    .mReadVal(mReadVal), .mHit(mHit), .mReadOnly(mReadOnly),
    .pmpCfg(pmpCfg), .pmpAddr(pmpAddr),
    .csrRdData(csrRdData), .csrIllegal(csrIllegal)
  );

endmodule

//--- csrTbTable.svh
//////////////////////////////
// Table of bus and trap steps for the CSR testbench
// Included inside the testbench module only
// Needs the Op* localparams and addRow
//////////////////////////////
`ifndef CSR_TB_TABLE_SVH
`define CSR_TB_TABLE_SVH

// Columns: op, address, write data, expected read data, expected err
// OpRndRd uses the expected column as a mask on the last random word
// OpTrap uses address as cause, write data as EPC, expected as tval
task automatic loadTable();
  // Writable registers are zero out of reset
  addRow(OpRd, `CSR_ADR_MSTATUS,       32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MTVEC,         32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MEDELEG,       32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MIDELEG,       32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MIE,           32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MSCRATCH,      32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MEPC,          32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MCAUSE,        32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MTVAL,         32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MCOUNTEREN,    32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MCOUNTINHIBIT, 32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPCFG0,       32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPCFG0 + 1,   32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0,      32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 7,  32'h0, 32'h0, 1'b0);
  // Fixed values and the ID block
  addRow(OpRd, `CSR_ADR_MISA,       32'h0, `CSR_MISA_VAL, 1'b0);
  addRow(OpRd, `CSR_ADR_MIMPID,     32'h0, `CSR_MIMPID_VAL, 1'b0);
  addRow(OpRd, `CSR_ADR_MVENDORID,  32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MARCHID,    32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MHARTID,    32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MCONFIGPTR, 32'h0, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MTINST,     32'h0, 32'h0, 1'b0);
  addRow(OpWr, `CSR_ADR_MVENDORID,  32'hFFFF_FFFF, 32'h0, 1'b1);
  addRow(OpRd, `CSR_ADR_MVENDORID,  32'h0, 32'h0, 1'b0);
  // mip follows the pin
  addRow(OpRd, `CSR_ADR_MIP,        32'h0, 32'h0000_0888, 1'b0);
  // Random round trips
  addRow(OpRndWr, `CSR_ADR_MSCRATCH,      32'h0, 32'h0, 1'b0);
  addRow(OpRndRd, `CSR_ADR_MSCRATCH,      32'h0, 32'hFFFF_FFFF, 1'b0);
  addRow(OpRndWr, `CSR_ADR_MIE,           32'h0, 32'h0, 1'b0);
  addRow(OpRndRd, `CSR_ADR_MIE,           32'h0, 32'h0000_0FFF, 1'b0);
  addRow(OpRndWr, `CSR_ADR_MCOUNTINHIBIT, 32'h0, 32'h0, 1'b0);
  addRow(OpRndRd, `CSR_ADR_MCOUNTINHIBIT, 32'h0, 32'hFFFF_FFFF, 1'b0);
  // mtvec bit 1 cleared, delegation masked
  addRow(OpWr, `CSR_ADR_MTVEC,   32'h8000_0107, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MTVEC,   32'h0, 32'h8000_0105, 1'b0);
  addRow(OpWr, `CSR_ADR_MEDELEG, 32'hFFFF_FFFF, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MEDELEG, 32'h0, 32'h0000_B3FF, 1'b0);
  addRow(OpWr, `CSR_ADR_MIDELEG, 32'hFFFF_FFFF, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_MIDELEG, 32'h0, 32'h0000_0222, 1'b0);
  // Unmapped addresses, then a normal access
  addRow(OpRd, 12'h7C0,                32'h0, 32'h0, 1'b1);
  addRow(OpWr, 12'h7C0,                32'h1, 32'h0, 1'b1);
  addRow(OpRd, `CSR_ADR_PMPCFG0 + 2,   32'h0, 32'h0, 1'b1);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 8,  32'h0, 32'h0, 1'b1);
  addRow(OpRd, `CSR_ADR_MISA,          32'h0, `CSR_MISA_VAL, 1'b0);
  // PMP round trips, no lock bits yet
  addRow(OpWr, `CSR_ADR_PMPCFG0,      32'h1B1A_1918, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPCFG0,      32'h0, 32'h1B1A_1918, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPADDR0 + 2, 32'h1234_5678, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 2, 32'h0, 32'h1234_5678, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPADDR0 + 3, 32'h0000_3333, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 3, 32'h0, 32'h0000_3333, 1'b0);
  // Entry 3 locked TOR, guards the address of entry 2
  addRow(OpWr, `CSR_ADR_PMPCFG0,      32'h8800_0000, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPCFG0,      32'h0, 32'h8800_0000, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPADDR0 + 2, 32'hDEAD_BEEF, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 2, 32'h0, 32'h1234_5678, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPADDR0 + 3, 32'h0000_4444, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 3, 32'h0, 32'h0000_3333, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPADDR0 + 1, 32'h0000_1111, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 1, 32'h0, 32'h0000_1111, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPADDR0 + 7, 32'h7777_0000, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPADDR0 + 7, 32'h0, 32'h7777_0000, 1'b0);
  // Entry 2 locks itself, bytes 0 and 1 still move
  addRow(OpWr, `CSR_ADR_PMPCFG0,      32'h0080_0017, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPCFG0,      32'h0, 32'h8880_0017, 1'b0);
  addRow(OpWr, `CSR_ADR_PMPCFG0,      32'h0000_0000, 32'h0, 1'b0);
  addRow(OpRd, `CSR_ADR_PMPCFG0,      32'h0, 32'h8880_0000, 1'b0);
  // Trap with MIE set, interrupt cause 3
  addRow(OpWr,   `CSR_ADR_MSTATUS, 32'h0000_0008, 32'h0, 1'b0);
  addRow(OpRd,   `CSR_ADR_MSTATUS, 32'h0, 32'h0000_0008, 1'b0);
  addRow(OpTrap, 12'h013,          32'h0000_1234, 32'hCAFE_F00D, 1'b0);
  addRow(OpRd,   `CSR_ADR_MEPC,    32'h0, 32'h0000_1234, 1'b0);
  addRow(OpRd,   `CSR_ADR_MCAUSE,  32'h0, 32'h8000_0003, 1'b0);
  addRow(OpRd,   `CSR_ADR_MTVAL,   32'h0, 32'hCAFE_F00D, 1'b0);
  addRow(OpRd,   `CSR_ADR_MSTATUS, 32'h0, 32'h0000_1880, 1'b0);
  // Second trap, exception cause 2, MIE already clear
  addRow(OpTrap, 12'h002,          32'h0000_2000, 32'h0000_00FF, 1'b0);
  addRow(OpRd,   `CSR_ADR_MCAUSE,  32'h0, 32'h0000_0002, 1'b0);
  addRow(OpRd,   `CSR_ADR_MSTATUS, 32'h0, 32'h0000_1800, 1'b0);
endtask

`endif

//--- csrTb.sv
//////////////////////////////
// Self-checking testbench for csrSubsystem
// Wishbone master drives on the falling edge
// Outputs sampled on the falling edge too
// Stops at the first mismatch
//////////////////////////////
`timescale 1ns/1ps
`include "csr_consts.svh"

module csrTb;
  import csrPkg::*;

  // Table operations
  localparam int OpRd    = 0;
  localparam int OpWr    = 1;
  localparam int OpRndWr = 2;
  localparam int OpRndRd = 3;
  localparam int OpTrap  = 4;

  logic       clk;
  logic       rstN;
  logic       wbCyc;
  logic       wbStb;
  logic       wbWe;
  csrAdr_t    wbAdr;
  csrWord_t   wbDatIn;
  csrWord_t   wbDatOut;
  logic       wbAck;
  logic       wbErr;
  logic       mTrap;
  csrWord_t   nextEpc;
  trapCause_t nextCause;
  csrWord_t   nextMtval;
  logic [11:0] mip;
  csrWord_t   mtvec;
  csrWord_t   mepc;
  logic [15:0] medeleg;
  logic [11:0] mideleg;
  logic [11:0] mie;
  logic       mstatusMie;

  // Table columns
  int       rowOp[$];
  csrAdr_t  rowAdr[$];
  csrWord_t rowWr[$];
  csrWord_t rowExp[$];
  logic     rowErr[$];

  int          cycles     = 0;
  int          cycleLimit = 0;
  logic [31:0] rndState;
  csrWord_t    lastRnd;
  csrWord_t    rdData;
  logic        rdErr;

  csrSubsystem u_dut (
    .clk(clk), .rstN(rstN),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatIn(wbDatIn),
    .wbDatOut(wbDatOut), .wbAck(wbAck), .wbErr(wbErr),
    .mTrap(mTrap), .nextEpc(nextEpc), .nextCause(nextCause), .nextMtval(nextMtval),
    .mip(mip),
    .mtvec(mtvec), .mepc(mepc), .medeleg(medeleg), .mideleg(mideleg),
    .mie(mie), .mstatusMie(mstatusMie)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic addRow(input int op, input csrAdr_t adr, input csrWord_t wr,
                        input csrWord_t exp, input logic err);
    rowOp.push_back(op);
    rowAdr.push_back(adr);
    rowWr.push_back(wr);
    rowExp.push_back(exp);
    rowErr.push_back(err);
  endtask

  `include "csrTbTable.svh"

  // 13/17/5 xorshift
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // Exported register ports follow the bus view of the same CSR
  task automatic verifyExports(input csrAdr_t adr, input csrWord_t exp);
    case (adr)
      `CSR_ADR_MTVEC:   checkEq("mtvec", mtvec, exp);
      `CSR_ADR_MEPC:    checkEq("mepc", mepc, exp);
      `CSR_ADR_MEDELEG: checkEq("medeleg", {16'b0, medeleg}, exp);
      `CSR_ADR_MIDELEG: checkEq("mideleg", {20'b0, mideleg}, exp);
      `CSR_ADR_MIE:     checkEq("mie", {20'b0, mie}, exp);
      `CSR_ADR_MSTATUS: checkEq("mstatusMie", {31'b0, mstatusMie}, {31'b0, exp[3]});
      default: ;
    endcase
  endtask

  // One classic cycle held until ack or err
  task automatic busAccess(input logic we, input csrAdr_t adr, input csrWord_t wdat,
                           output csrWord_t rdat, output logic err);
    @(negedge clk);
    wbCyc   = 1'b1;
    wbStb   = 1'b1;
    wbWe    = we;
    wbAdr   = adr;
    wbDatIn = wdat;
    do begin
      @(negedge clk);
    end while (!(wbAck || wbErr));
    rdat  = wbDatOut;
    err   = wbErr;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  // One-cycle trap pulse with the exported ports checked after the edge
  task automatic trapPulse(input trapCause_t cause, input csrWord_t epc, input csrWord_t tval);
    @(negedge clk);
    mTrap     = 1'b1;
    nextCause = cause;
    nextEpc   = epc;
    nextMtval = tval;
    @(negedge clk);
    mTrap = 1'b0;
    checkEq("mepc", mepc, epc);
    checkEq("mstatusMie", {31'b0, mstatusMie}, 32'h0);
  endtask

  //////////////////////////////
  // Clock and cycle limit
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Run did not finish within %0d cycles", cycleLimit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rstN      = 1'b0;
    wbCyc     = 1'b0;
    wbStb     = 1'b0;
    wbWe      = 1'b0;
    wbAdr     = '0;
    wbDatIn   = '0;
    mTrap     = 1'b0;
    nextEpc   = '0;
    nextCause = '0;
    nextMtval = '0;
    mip       = 12'h888;
    rndState  = 32'h86b0_b082;
    lastRnd   = '0;
    loadTable();
    cycleLimit = 20 * rowOp.size() + 200;
    // Four rising edges in reset
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    checkEq("wbAck", {31'b0, wbAck}, 32'h0);
    checkEq("wbErr", {31'b0, wbErr}, 32'h0);
    for (int i = 0; i < rowOp.size(); i++) begin
      case (rowOp[i])
        OpRd: begin
          busAccess(1'b0, rowAdr[i], '0, rdData, rdErr);
          checkEq($sformatf("wbErr row %0d", i), {31'b0, rdErr}, {31'b0, rowErr[i]});
          checkEq($sformatf("wbDatOut row %0d", i), rdData, rowExp[i]);
          verifyExports(rowAdr[i], rowExp[i]);
        end
        OpWr: begin
          busAccess(1'b1, rowAdr[i], rowWr[i], rdData, rdErr);
          checkEq($sformatf("wbErr row %0d", i), {31'b0, rdErr}, {31'b0, rowErr[i]});
        end
        OpRndWr: begin
          rndState = xorshift32(rndState);
          lastRnd  = rndState;
          busAccess(1'b1, rowAdr[i], lastRnd, rdData, rdErr);
          checkEq($sformatf("wbErr row %0d", i), {31'b0, rdErr}, {31'b0, rowErr[i]});
        end
        OpRndRd: begin
          // Unimplemented bits read as zero
          busAccess(1'b0, rowAdr[i], '0, rdData, rdErr);
          checkEq($sformatf("wbErr row %0d", i), {31'b0, rdErr}, {31'b0, rowErr[i]});
          checkEq($sformatf("wbDatOut row %0d", i), rdData, lastRnd & rowExp[i]);
          verifyExports(rowAdr[i], lastRnd & rowExp[i]);
        end
        OpTrap: begin
          trapPulse(trapCause_t'(rowAdr[i][4:0]), rowWr[i], rowExp[i]);
        end
        default: begin
          $display("Table row %0d holds an unknown operation", i);
          $display("** FAIL **");
          $fatal(1, "bad table");
        end
      endcase
    end
    $display("** PASS **");
    $finish;
  end

endmodule

//--- csr_consts.svh
//////////////////////////////
// Shared constants of the machine CSR block
// RV32 only, no XLEN switch
// PMP entry count must be a multiple of 4
// PMP address registers hold PA bits 33:2
//////////////////////////////
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Widths
`define CSR_XLEN        32
`define CSR_PMP_ENTRIES 8
`define CSR_PA_BITS     34

// Machine CSR addresses
`define CSR_ADR_MSTATUS       12'h300
`define CSR_ADR_MISA          12'h301
`define CSR_ADR_MEDELEG       12'h302
`define CSR_ADR_MIDELEG       12'h303
`define CSR_ADR_MIE           12'h304
`define CSR_ADR_MTVEC         12'h305
`define CSR_ADR_MCOUNTEREN    12'h306
`define CSR_ADR_MCOUNTINHIBIT 12'h320
`define CSR_ADR_MSCRATCH      12'h340
`define CSR_ADR_MEPC          12'h341
`define CSR_ADR_MCAUSE        12'h342
`define CSR_ADR_MTVAL         12'h343
`define CSR_ADR_MIP           12'h344
`define CSR_ADR_MTINST        12'h34A
`define CSR_ADR_PMPCFG0       12'h3A0
`define CSR_ADR_PMPADDR0      12'h3B0
`define CSR_ADR_MVENDORID     12'hF11
`define CSR_ADR_MARCHID       12'hF12
`define CSR_ADR_MIMPID        12'hF13
`define CSR_ADR_MHARTID       12'hF14
`define CSR_ADR_MCONFIGPTR    12'hF15

// Fixed read values, MXL=1 with I and M
`define CSR_MISA_VAL   32'h4000_1100
`define CSR_MIMPID_VAL 32'h0000_0100

// Delegation write masks
`define CSR_MEDELEG_MASK 16'hB3FF
`define CSR_MIDELEG_MASK 12'h222

`endif

//--- filelist.f
+incdir+.
csrPkg.sv
csrBusPort.sv
pmpEntry.sv
csrMachine.sv
csrReadSel.sv
csrSubsystem.sv
csrTb.sv

//--- pmpEntry.sv
//////////////////////////////
// One PMP entry, cfg byte and address
// Lock bit blocks its own cfg and addr writes
// Locked TOR next entry blocks addr writes
// No address matching here
//////////////////////////////
`timescale 1ns/1ps
`include "csr_consts.svh"

module pmpEntry #(
  parameter int unsigned Index = 0
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    csrWrite,
  input  csrPkg::csrAdr_t         csrAdr,
  input  csrPkg::csrWord_t        csrWrData,
  input  logic                    nextLocked,
  input  logic                    nextTor,
  output logic [7:0]              cfg,
  output logic [`CSR_PA_BITS-3:0] addr,
  output logic                    locked,
  output logic                    tor
);
  import csrPkg::*;

  // Four cfg bytes share one pmpcfg register
  localparam csrAdr_t     CfgAdr  = csrAdr_t'(`CSR_ADR_PMPCFG0 + Index / 4);
  localparam csrAdr_t     AddrAdr = csrAdr_t'(`CSR_ADR_PMPADDR0 + Index);
  // Bit offset of this entry's byte lane
  localparam int unsigned Lane    = (Index % 4) * 8;

  logic wrCfg;
  logic wrAddr;

  // L bit and A field as seen by the previous entry
  assign locked = cfg[7];
  assign tor    = (cfg[4:3] == 2'b01);

  assign wrCfg  = csrWrite & (csrAdr == CfgAdr) & ~locked;
  // Locked TOR above uses this address as its bottom
  assign wrAddr = csrWrite & (csrAdr == AddrAdr) & ~locked & ~(nextLocked & nextTor);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cfg  <= '0;
      addr <= '0;
    end else begin
      if (wrCfg) begin
        cfg <= csrWrData[Lane +: 8];
      end
      if (wrAddr) begin
        addr <= csrWrData[`CSR_PA_BITS-3:0];
      end
    end
  end

  // Once locked the byte holds until reset
  assert property (@(posedge clk) disable iff (!rstN) locked |=> $stable(cfg))
    else $error("locked PMP cfg changed");

endmodule
